// ==== project.f ====
source/tag_store_pkg.sv
source/tag_way_ram.sv
source/tag_victim_select.sv
source/tag_store_ctrl.sv
source/tag_store.sv
verif/tag_store_assertions.sv
verif/tag_store_tb.sv

// ==== verif/tag_store_tb.sv ====
// Testbench for the tag store
// Directed and random requests against a behavioral tag model, with back-pressure
`timescale 1ns/100ps
`default_nettype none

module tag_store_tb import tag_store_pkg::*;;

  // About 50 requests of under 10 cycles each, plus gaps, times four
  localparam int unsigned TimeoutCycles = 2000;

  logic     clk;
  logic     arst_n;
  way_ind_t spm_lock;
  tag_req_t req;
  logic     req_valid;
  logic     req_ready;
  tag_res_t res;
  logic     res_valid;
  logic     res_ready;

  // Model copy of every line
  logic model_val [NumSets][NumWays];
  logic model_dit [NumSets][NumWays];
  tag_t model_tag [NumSets][NumWays];

  integer      seed;
  logic        bp_enable;
  int unsigned cycle_count;
  int unsigned check_count;
  int unsigned error_count;
  int unsigned test_count;
  int unsigned test_errors_start;

  tag_store u_tag_store (
    .clk_i      (clk),
    .arst_n_i   (arst_n),
    .spm_lock_i (spm_lock),
    .req_i      (req),
    .valid_i    (req_valid),
    .ready_o    (req_ready),
    .res_o      (res),
    .valid_o    (res_valid),
    .ready_i    (res_ready)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TimeoutCycles) begin
      $display("Timeout: run did not finish within %0d cycles", TimeoutCycles);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  task automatic check_field(input string name, input logic [31:0] exp, input logic [31:0] got);
    check_count++;
    if (exp !== got) begin
      error_count++;
      $display("CHECK FAILED at %0t: %s expected 0x%0h got 0x%0h", $time, name, exp, got);
    end
  endtask

  // Expected response from the cache rules, then the model takes the write-back
  task automatic predict(input tag_req_t r, output tag_res_t exp, output logic wb);
    int       way;
    int       s;
    way_ind_t elig;
    way = -1;
    s = int'(r.index);
    exp = '0;
    wb = 1'b0;
    if (r.mode == MODE_FLUSH) begin
      for (int w = 0; w < NumWays; w++) begin
        if (r.indicator[w]) begin
          way = w;
        end
      end
      exp.indicator = r.indicator;
      exp.evict     = model_val[s][way] && model_dit[s][way];
      exp.evict_tag = model_tag[s][way];
      wb = 1'b1;
      model_val[s][way] = 1'b0;
      model_dit[s][way] = 1'b0;
      model_tag[s][way] = '0;
      return;
    end
    for (int w = 0; w < NumWays; w++) begin
      if (way < 0 && r.indicator[w] && model_val[s][w] && model_tag[s][w] == r.tag) begin
        way = w;
      end
    end
    if (way >= 0) begin
      exp.indicator = way_ind_t'(1) << way;
      exp.hit = 1'b1;
      wb = r.dirty && !model_dit[s][way];
      if (wb) begin
        model_dit[s][way] = 1'b1;
      end
      return;
    end
    // Miss: invalid way, then clean way, then any eligible way
    elig = r.indicator & ~spm_lock;
    for (int w = 0; w < NumWays; w++) begin
      if (way < 0 && elig[w] && !model_val[s][w]) begin
        way = w;
      end
    end
    for (int w = 0; w < NumWays; w++) begin
      if (way < 0 && elig[w] && !model_dit[s][w]) begin
        way = w;
      end
    end
    for (int w = 0; w < NumWays; w++) begin
      if (way < 0 && elig[w]) begin
        way = w;
      end
    end
    if (way >= 0) begin
      exp.indicator = way_ind_t'(1) << way;
      exp.evict     = model_val[s][way] && model_dit[s][way];
      exp.evict_tag = model_tag[s][way];
      wb = 1'b1;
      model_val[s][way] = 1'b1;
      model_dit[s][way] = r.dirty;
      model_tag[s][way] = r.tag;
    end
  endtask

  // Holds the request until the accept edge, returns 2 ns after it
  task automatic issue_request(input tag_req_t r);
    logic accepted;
    accepted = 1'b0;
    req = r;
    req_valid = 1'b1;
    while (!accepted) begin
      accepted = req_ready;
      @(posedge clk);
      #2;
    end
    req_valid = 1'b0;
  endtask

  task automatic collect_response(output tag_res_t got);
    logic        done;
    logic [31:0] rnd;
    done = 1'b0;
    got = '0;
    while (!done) begin
      if (bp_enable) begin
        rnd = $random(seed);
        res_ready = (rnd[1:0] != 2'b00);
      end else begin
        res_ready = 1'b1;
      end
      done = res_valid && res_ready;
      got = res;
      @(posedge clk);
      #2;
    end
    res_ready = 1'b0;
  endtask

  task automatic run_request(input tag_req_t r);
    tag_res_t exp;
    tag_res_t got;
    logic     wb;
    predict(r, exp, wb);
    issue_request(r);
    collect_response(got);
    check_field("res_o.indicator", exp.indicator, got.indicator);
    check_field("res_o.hit", exp.hit, got.hit);
    check_field("res_o.evict", exp.evict, got.evict);
    check_field("res_o.evict_tag", exp.evict_tag, got.evict_tag);
    // Write cycle keeps the request side closed one more cycle
    check_field("ready_o", !wb, req_ready);
  endtask

  task automatic lookup(input int s, input int t, input way_ind_t mask, input logic dirty);
    tag_req_t r;
    r = '{mode: MODE_LOOKUP, indicator: mask, index: index_t'(s), tag: tag_t'(t), dirty: dirty};
    run_request(r);
  endtask

  task automatic flush(input int s, input int way);
    tag_req_t r;
    r = '{mode: MODE_FLUSH, indicator: way_ind_t'(1) << way, index: index_t'(s),
          tag: '0, dirty: 1'b0};
    run_request(r);
  endtask

  task automatic start_test();
    test_errors_start = error_count;
  endtask

  task automatic finish_test(input string name);
    test_count++;
    $display("Test %0d %s finished with %0d mismatches", test_count, name,
             error_count - test_errors_start);
  endtask

  initial begin
    logic [31:0] rnd;
    clk = 1'b0;
    arst_n = 1'b0;
    spm_lock = '0;
    req = '0;
    req_valid = 1'b0;
    res_ready = 1'b0;
    bp_enable = 1'b0;
    seed = 32'hc6b3;
    cycle_count = 0;
    check_count = 0;
    error_count = 0;
    test_count = 0;
    for (int s = 0; s < NumSets; s++) begin
      for (int w = 0; w < NumWays; w++) begin
        model_val[s][w] = 1'b0;
        model_dit[s][w] = 1'b0;
        model_tag[s][w] = '0;
      end
    end
    repeat (3) @(posedge clk);
    #2;
    arst_n = 1'b1;
    @(posedge clk);
    #2;

    start_test();
    lookup(1, 'h055, 4'hf, 1'b0);
    lookup(1, 'h055, 4'hf, 1'b0);
    finish_test("miss_on_empty_set");

    // Clean fill, dirty hit, flush of the dirty line, then a miss
    start_test();
    lookup(2, 'h0a1, 4'hf, 1'b0);
    lookup(2, 'h0a1, 4'hf, 1'b1);
    flush(2, 0);
    lookup(2, 'h0a1, 4'hf, 1'b0);
    finish_test("dirty_upgrade");

    start_test();
    lookup(3, 'h101, 4'hf, 1'b1);
    lookup(3, 'h102, 4'hf, 1'b0);
    lookup(3, 'h103, 4'hf, 1'b1);
    lookup(3, 'h104, 4'hf, 1'b0);
    lookup(3, 'h105, 4'hf, 1'b0);
    lookup(3, 'h105, 4'hf, 1'b1);
    lookup(3, 'h104, 4'hf, 1'b1);
    lookup(3, 'h106, 4'hf, 1'b0);
    finish_test("victim_priority");

    // Ways 0 and 1 held as scratchpad, partial masks narrow hit and victim
    start_test();
    spm_lock = 4'b0011;
    lookup(4, 'h201, 4'hf, 1'b0);
    lookup(4, 'h202, 4'hf, 1'b0);
    lookup(4, 'h203, 4'hf, 1'b0);
    lookup(4, 'h202, 4'b0101, 1'b0);
    lookup(4, 'h202, 4'b1000, 1'b0);
    spm_lock = '0;
    finish_test("spm_lock");

    start_test();
    bp_enable = 1'b1;
    for (int i = 0; i < 24; i++) begin
      rnd = $random(seed);
      if (rnd[4:2] == 3'd0) begin
        flush(8 + int'(rnd[5]), int'(rnd[7:6]));
      end else begin
        lookup(8 + int'(rnd[5]), 'h300 + int'(rnd[10:8]) % 6, 4'hf, rnd[11]);
      end
    end
    bp_enable = 1'b0;
    finish_test("back_pressure");

    repeat (2) @(posedge clk);
    $display("Tests: %0d, checks: %0d, mismatches: %0d, assertion failures: %0d",
             test_count, check_count, error_count, u_tag_store.u_assertions.fail_count);
    if (error_count == 0 && u_tag_store.u_assertions.fail_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verif/tag_store_assertions.sv ====
// Protocol and response checks for the tag store
// Bound into the top level, watches both handshakes
`timescale 1ns/100ps
`default_nettype none

module tag_store_assertions import tag_store_pkg::*; (
  input wire logic     clk_i,
  input wire logic     arst_n_i,
  input wire logic     valid_i,
  input wire logic     ready_o,
  input wire tag_res_t res_o,
  input wire logic     valid_o,
  input wire logic     ready_i
);

  // Number of failed assertions
  int unsigned fail_count = 0;

  // Held response must not move until it is taken
  a_resp_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    valid_o && !ready_i |=> valid_o && $stable(res_o))
    else begin
      fail_count++;
      $error("response changed or dropped while back-pressured");
    end

  a_resp_done: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    valid_o && ready_i |=> !valid_o)
    else begin
      fail_count++;
      $error("valid_o still high after the response transfer");
    end

  a_ind_onehot: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    valid_o |-> $onehot(res_o.indicator))
    else begin
      fail_count++;
      $error("response indicator is not one-hot");
    end

  a_hit_evict: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    valid_o |-> !(res_o.hit && res_o.evict))
    else begin
      fail_count++;
      $error("hit and evict both high");
    end

  // No response pending while reset is applied
  a_reset_idle: assert property (@(posedge clk_i)
    !arst_n_i |-> !valid_o && ready_o)
    else begin
      fail_count++;
      $error("outputs not idle during reset");
    end

  // Accept edge, one read cycle, then the response
  a_resp_latency: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    valid_i && ready_o |=> !valid_o ##1 valid_o)
    else begin
      fail_count++;
      $error("valid_o did not rise two cycles after acceptance");
    end

endmodule

bind tag_store tag_store_assertions u_assertions (
  .clk_i    (clk_i),
  .arst_n_i (arst_n_i),
  .valid_i  (valid_i),
  .ready_o  (ready_o),
  .res_o    (res_o),
  .valid_o  (valid_o),
  .ready_i  (ready_i)
);

`default_nettype wire

// ==== source/tag_store.sv ====
// Last-level cache tag store
// Controller, one tag RAM per way and the victim selector
`timescale 1ns/100ps
`default_nettype none

module tag_store import tag_store_pkg::*; (
  input  wire logic     clk_i,
  input  wire logic     arst_n_i,
  input  wire way_ind_t spm_lock_i,
  input  wire tag_req_t req_i,
  input  wire logic     valid_i,
  output logic          ready_o,
  output tag_res_t      res_o,
  output logic          valid_o,
  input  wire logic     ready_i
);

  way_ind_t                 ram_req;
  way_ind_t                 ram_we;
  index_t                   ram_index;
  tag_entry_t               ram_wdata;
  tag_t                     cmp_tag;
  tag_entry_t [NumWays-1:0] ram_rdata;
  way_ind_t                 ram_match;
  way_ind_t                 way_valid;
  way_ind_t                 way_dirty;
  way_ind_t                 req_mask;
  way_ind_t                 victim;
  logic                     victim_evict;

  tag_store_ctrl u_ctrl (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .req_i       (req_i),
    .valid_i     (valid_i),
    .ready_o     (ready_o),
    .res_o       (res_o),
    .valid_o     (valid_o),
    .ready_i     (ready_i),
    .ram_req_o   (ram_req),
    .ram_we_o    (ram_we),
    .ram_index_o (ram_index),
    .ram_wdata_o (ram_wdata),
    .cmp_tag_o   (cmp_tag),
    .rdata_i     (ram_rdata),
    .match_i     (ram_match),
    .req_mask_o  (req_mask),
    .victim_i    (victim),
    .evict_i     (victim_evict)
  );

  // One RAM per way, status bits gathered for the victim selector
  for (genvar w = 0; w < NumWays; w++) begin : gen_way
    tag_way_ram u_way (
      .clk_i     (clk_i),
      .arst_n_i  (arst_n_i),
      .req_i     (ram_req[w]),
      .we_i      (ram_we[w]),
      .index_i   (ram_index),
      .wdata_i   (ram_wdata),
      .cmp_tag_i (cmp_tag),
      .rdata_o   (ram_rdata[w]),
      .match_o   (ram_match[w])
    );
    assign way_valid[w] = ram_rdata[w].val;
    assign way_dirty[w] = ram_rdata[w].dit;
  end

  tag_victim_select u_victim (
    .valid_i    (way_valid),
    .dirty_i    (way_dirty),
    .spm_lock_i (spm_lock_i),
    .req_mask_i (req_mask),
    .victim_o   (victim),
    .evict_o    (victim_evict)
  );

endmodule

`default_nettype wire

// ==== source/tag_store_ctrl.sv ====
// Tag store controller
// Request FSM, way RAM command steering and response assembly
`timescale 1ns/100ps
`default_nettype none

module tag_store_ctrl import tag_store_pkg::*; (
  input  wire logic                     clk_i,
  input  wire logic                     arst_n_i,
  input  wire tag_req_t                 req_i,
  input  wire logic                     valid_i,
  output logic                          ready_o,
  output tag_res_t                      res_o,
  output logic                          valid_o,
  input  wire logic                     ready_i,
  output way_ind_t                      ram_req_o,
  output way_ind_t                      ram_we_o,
  output index_t                        ram_index_o,
  output tag_entry_t                    ram_wdata_o,
  output tag_t                          cmp_tag_o,
  input  wire tag_entry_t [NumWays-1:0] rdata_i,
  input  wire way_ind_t                 match_i,
  output way_ind_t                      req_mask_o,
  input  wire way_ind_t                 victim_i,
  input  wire logic                     evict_i
);

  ctrl_state_e state_q;
  ctrl_state_e state_d;

  // Accepted request, payload only
  tag_req_t req_q;
  logic     load_req;

  way_ind_t   hit;
  logic       is_hit;
  way_ind_t   sel_way;
  way_bin_t   sel_bin;
  tag_entry_t sel_entry;
  logic       wb_needed;
  tag_entry_t wb_data;

  function automatic way_bin_t onehot_to_bin(way_ind_t oh);
    way_bin_t bin;
    bin = '0;
    for (int unsigned w = 0; w < NumWays; w++) begin
      if (oh[w]) begin
        bin = bin | way_bin_t'(w);
      end
    end
    return bin;
  endfunction

  always_ff @(posedge clk_i) begin
    if (load_req) begin
      req_q <= req_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Compare runs against the stored tag and mask
  assign cmp_tag_o  = req_q.tag;
  assign req_mask_o = req_q.indicator;

  // Match bits of disabled ways may be stale
  assign hit    = match_i & req_q.indicator;
  assign is_hit = |hit;

  // Way the response talks about
  always_comb begin
    if (req_q.mode == MODE_FLUSH) begin
      sel_way = req_q.indicator;
    end else if (is_hit) begin
      sel_way = hit;
    end else begin
      sel_way = victim_i;
    end
  end

  assign sel_bin   = onehot_to_bin(sel_way);
  assign sel_entry = rdata_i[sel_bin];

  // Write-back decision and data
  // A lookup hit only writes when the request is dirty, so dit follows the request
  always_comb begin
    if (req_q.mode == MODE_FLUSH) begin
      wb_needed = 1'b1;
      wb_data   = '0;
    end else begin
      wb_needed = is_hit ? (req_q.dirty && !sel_entry.dit) : (|victim_i);
      wb_data   = '{val: 1'b1, dit: req_q.dirty, tag: req_q.tag};
    end
  end

  // Response from held RAM data, stable while in ST_RESP
  always_comb begin
    res_o.indicator = sel_way;
    if (req_q.mode == MODE_FLUSH) begin
      res_o.hit       = 1'b0;
      res_o.evict     = sel_entry.val & sel_entry.dit;
      res_o.evict_tag = sel_entry.tag;
    end else if (is_hit) begin
      res_o.hit       = 1'b1;
      res_o.evict     = 1'b0;
      res_o.evict_tag = '0;
    end else begin
      res_o.hit       = 1'b0;
      res_o.evict     = evict_i;
      res_o.evict_tag = sel_entry.tag;
    end
  end

  always_comb begin
    state_d     = state_q;
    load_req    = 1'b0;
    ram_req_o   = '0;
    ram_we_o    = '0;
    ram_index_o = req_q.index;
    ram_wdata_o = wb_data;
    unique case (state_q)
      ST_IDLE: begin
        // Read issued in the accept cycle, data lands with the request
        ram_index_o = req_i.index;
        if (valid_i) begin
          ram_req_o = req_i.indicator;
          load_req  = 1'b1;
          state_d   = ST_READ;
        end
      end
      ST_READ: begin
        state_d = ST_RESP;
      end
      ST_RESP: begin
        // RAM idle here so the read word stays put under back-pressure
        if (ready_i) begin
          state_d = wb_needed ? ST_WRITE : ST_IDLE;
        end
      end
      ST_WRITE: begin
        ram_req_o = sel_way;
        ram_we_o  = sel_way;
        state_d   = ST_IDLE;
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  assign ready_o = (state_q == ST_IDLE);
  assign valid_o = (state_q == ST_RESP);

endmodule

`default_nettype wire

// ==== source/tag_victim_select.sv ====
// Victim way selector for a lookup miss
// Fixed priority: invalid way first, then clean way, then any eligible way
`timescale 1ns/100ps
`default_nettype none

module tag_victim_select import tag_store_pkg::*; (
  input  wire way_ind_t valid_i,
  input  wire way_ind_t dirty_i,
  input  wire way_ind_t spm_lock_i,
  input  wire way_ind_t req_mask_i,
  output way_ind_t      victim_o,
  output logic          evict_o
);

  way_ind_t eligible;
  way_ind_t free_ways;
  way_ind_t clean_ways;
  way_ind_t candidates;

  // SPM ways and ways outside the request mask are never replaced
  assign eligible   = req_mask_i & ~spm_lock_i;
  assign free_ways  = eligible & ~valid_i;
  assign clean_ways = eligible & ~dirty_i;

  always_comb begin
    if (|free_ways) begin
      candidates = free_ways;
    end else if (|clean_ways) begin
      candidates = clean_ways;
    end else begin
      candidates = eligible;
    end
  end

  // Isolate lowest set bit
  // Zero when nothing is eligible
  assign victim_o = candidates & (~candidates + way_ind_t'(1));

  // Old line has to go out when it holds modified data
  assign evict_o = |(victim_o & valid_i & dirty_i);

endmodule

`default_nettype wire

// ==== source/tag_way_ram.sv ====
// Tag RAM of one cache way
// Registered read port, reset-cleared entries and tag compare on the read word
`timescale 1ns/100ps
`default_nettype none

module tag_way_ram import tag_store_pkg::*; (
  input  wire logic       clk_i,
  input  wire logic       arst_n_i,
  input  wire logic       req_i,
  input  wire logic       we_i,
  input  wire index_t     index_i,
  input  wire tag_entry_t wdata_i,
  input  wire tag_t       cmp_tag_i,
  output tag_entry_t      rdata_o,
  output logic            match_o
);

  // One entry per set
  tag_entry_t mem [NumSets];
  tag_entry_t rdata_q;

  // All lines start invalid and clean
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int unsigned s = 0; s < NumSets; s++) begin
        mem[s] <= '0;
      end
    end else if (req_i && we_i) begin
      mem[index_i] <= wdata_i;
    end
  end

  // Read word is held until the next read
  // Writes leave it untouched
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rdata_q <= '0;
    end else if (req_i && !we_i) begin
      rdata_q <= mem[index_i];
    end
  end

  assign rdata_o = rdata_q;

  // Only a valid line can match
  assign match_o = rdata_q.val && (rdata_q.tag == cmp_tag_i);

endmodule

`default_nettype wire

// ==== source/tag_store_pkg.sv ====
// Tag store shared definitions
// Widths, vector types, state encodings and the request/response structs
`default_nettype none

package tag_store_pkg;

  // Geometry
  localparam int unsigned NumWays     = 4;
  localparam int unsigned WayBinWidth = $clog2(NumWays);
  localparam int unsigned IndexWidth  = 4;
  localparam int unsigned NumSets     = 2 ** IndexWidth;
  localparam int unsigned TagWidth    = 10;

  typedef logic [NumWays-1:0]     way_ind_t;
  typedef logic [WayBinWidth-1:0] way_bin_t;
  typedef logic [IndexWidth-1:0]  index_t;
  typedef logic [TagWidth-1:0]    tag_t;

  typedef enum logic {
    MODE_LOOKUP = 1'b0,
    MODE_FLUSH  = 1'b1
  } tag_mode_e;

  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,
    ST_READ  = 2'd1,
    ST_RESP  = 2'd2,
    ST_WRITE = 2'd3
  } ctrl_state_e;

  // Word held in each way RAM
  typedef struct packed {
    logic val;
    logic dit;
    tag_t tag;
  } tag_entry_t;

  // Indicator is a way mask for lookup, one-hot way for flush
  typedef struct packed {
    tag_mode_e mode;
    way_ind_t  indicator;
    index_t    index;
    tag_t      tag;
    logic      dirty;
  } tag_req_t;

  typedef struct packed {
    way_ind_t indicator;
    logic     hit;
    logic     evict;
    tag_t     evict_tag;
  } tag_res_t;

endpackage

`default_nettype wire
